/* common/ahb_pkg.sv */
package ahb_pkg;

    // ------------------------------
    // Bus encodings
    // ------------------------------

    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_BUSY   = 2'b01;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    localparam logic [2:0] HSIZE_BYTE = 3'b000;
    localparam logic [2:0] HSIZE_HALF = 3'b001;
    localparam logic [2:0] HSIZE_WORD = 3'b010;

    localparam logic HRESP_OKAY  = 1'b0;
    localparam logic HRESP_ERROR = 1'b1;

    // ------------------------------
    // Memory map
    // ------------------------------

    // 1024 words of on-chip RAM, 4 KB in all
    localparam int RAM_ADDR_WIDTH = 10;

    localparam logic [31:0] RAM_BASE = 32'h0000_0000;
    localparam logic [31:0] RAM_MASK = 32'hFFFF_F000;

    localparam logic [31:0] GPIO_BASE = 32'h1F80_0000;
    localparam logic [31:0] GPIO_MASK = 32'hFFFF_F000;

    localparam int RAM_WAIT_STATES = 1;

    // ------------------------------
    // GPIO registers
    // ------------------------------

    // Switches and buttons are read only, the LED registers read and write
    localparam logic [7:0] GPIO_SWITCHES_OFS   = 8'h00;
    localparam logic [7:0] GPIO_BUTTONS_OFS    = 8'h04;
    localparam logic [7:0] GPIO_RED_LEDS_OFS   = 8'h08;
    localparam logic [7:0] GPIO_GREEN_LEDS_OFS = 8'h0C;

    localparam int N_SWITCHES   = 16;
    localparam int N_BUTTONS    = 4;
    localparam int N_RED_LEDS   = 16;
    localparam int N_GREEN_LEDS = 8;

    // Position of each slave in the select vector
    localparam int SLAVE_RAM  = 0;
    localparam int SLAVE_GPIO = 1;
    localparam int N_SLAVES   = 2;

endpackage

/* common/ahb_slave_if.sv */
`timescale 1ns/10ps

interface ahb_slave_if;

    // Address phase, driven by the fabric
    logic        hsel;
    logic [31:0] haddr;
    logic [1:0]  htrans;
    logic        hwrite;
    logic [2:0]  hsize;
    logic [31:0] hwdata;

    // Slave response for the data phase
    logic [31:0] hrdata;
    logic        hreadyout;
    logic        hresp;

    // Bus-wide ready, fed back to every slave
    logic        hready;

    modport slave (
        input  hsel, haddr, htrans, hwrite, hsize, hwdata, hready,
        output hrdata, hreadyout, hresp
    );

    modport fabric (
        output hsel, haddr, htrans, hwrite, hsize, hwdata, hready,
        input  hrdata, hreadyout, hresp
    );

endinterface

/* ram/ahb_ram_slave.sv */
`timescale 1ns/10ps

module ahb_ram_slave #(
    parameter int WAIT_STATES = ahb_pkg::RAM_WAIT_STATES
) (
    input  logic         HCLK,
    input  logic         reset,
    ahb_slave_if.slave   bus
);

    localparam int WORDS = 2 ** ahb_pkg::RAM_ADDR_WIDTH;
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [31:0] mem [0:WORDS-1];

    logic                              accept;
    logic                              active_q;
    logic                              write_q;
    logic [2:0]                        size_q;
    logic [ahb_pkg::RAM_ADDR_WIDTH+1:0] addr_q;
    logic [CNT_W-1:0]                  wait_cnt;
    logic [3:0]                        byte_en;
    logic                              do_write;

    assign accept = bus.hsel && bus.hready && bus.htrans[1];

    // ------------------------------
    // Address phase capture
    // ------------------------------

    always_ff @(posedge HCLK) begin
        if (reset) begin
            active_q <= 1'b0;
            wait_cnt <= '0;
        end else begin
            if (bus.hready) begin
                active_q <= accept;
            end
            if (accept) begin
                wait_cnt <= CNT_W'(WAIT_STATES);
            end else if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            write_q <= bus.hwrite;
            size_q  <= bus.hsize;
            addr_q  <= bus.haddr[ahb_pkg::RAM_ADDR_WIDTH+1:0];
        end
    end

    // Slave stalls the bus until the wait count has drained
    assign bus.hreadyout = (wait_cnt == '0);
    assign bus.hresp     = ahb_pkg::HRESP_OKAY;

    // ------------------------------
    // Byte lanes and storage
    // ------------------------------

    always_comb begin
        case (size_q)
            ahb_pkg::HSIZE_BYTE: byte_en = 4'b0001 << addr_q[1:0];
            ahb_pkg::HSIZE_HALF: byte_en = addr_q[1] ? 4'b1100 : 4'b0011;
            default:             byte_en = 4'b1111;
        endcase
    end

    // The data phase ends on the edge where the bus is ready again
    assign do_write = active_q && write_q && bus.hready;

    always_ff @(posedge HCLK) begin
        if (do_write) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[addr_q[ahb_pkg::RAM_ADDR_WIDTH+1:2]][i*8 +: 8] <= bus.hwdata[i*8 +: 8];
                end
            end
        end
    end

    // Reads return the whole word, the master picks its lanes
    assign bus.hrdata = mem[addr_q[ahb_pkg::RAM_ADDR_WIDTH+1:2]];

endmodule

/* gpio/ahb_gpio_slave.sv */
`timescale 1ns/10ps

module ahb_gpio_slave (
    input  logic                             HCLK,
    input  logic                             reset,
    ahb_slave_if.slave                       bus,
    input  logic [ahb_pkg::N_SWITCHES-1:0]   switches,
    input  logic [ahb_pkg::N_BUTTONS-1:0]    buttons,
    output logic [ahb_pkg::N_RED_LEDS-1:0]   red_leds,
    output logic [ahb_pkg::N_GREEN_LEDS-1:0] green_leds
);

    logic [ahb_pkg::N_SWITCHES-1:0] sw_meta;
    logic [ahb_pkg::N_SWITCHES-1:0] sw_sync;
    logic [ahb_pkg::N_BUTTONS-1:0]  btn_meta;
    logic [ahb_pkg::N_BUTTONS-1:0]  btn_sync;

    logic        accept;
    logic        active_q;
    logic        write_q;
    logic [2:0]  size_q;
    logic [31:0] ofs_q;
    logic        word_write;

    // ------------------------------
    // Input synchronizers
    // ------------------------------

    always_ff @(posedge HCLK) begin
        sw_meta  <= switches;
        sw_sync  <= sw_meta;
        btn_meta <= buttons;
        btn_sync <= btn_meta;
    end

    // ------------------------------
    // Bus side
    // ------------------------------

    assign accept = bus.hsel && bus.hready && bus.htrans[1];

    always_ff @(posedge HCLK) begin
        if (reset) begin
            active_q <= 1'b0;
        end else if (bus.hready) begin
            active_q <= accept;
        end
    end

    // Only the offset inside the 4 KB region matters from here on
    always_ff @(posedge HCLK) begin
        if (accept) begin
            write_q <= bus.hwrite;
            size_q  <= bus.hsize;
            ofs_q   <= bus.haddr & ~ahb_pkg::GPIO_MASK;
        end
    end

    assign word_write = active_q && write_q && bus.hready && (size_q == ahb_pkg::HSIZE_WORD);

    always_ff @(posedge HCLK) begin
        if (reset) begin
            red_leds   <= '0;
            green_leds <= '0;
        end else if (word_write) begin
            if (ofs_q == 32'(ahb_pkg::GPIO_RED_LEDS_OFS)) begin
                red_leds <= bus.hwdata[ahb_pkg::N_RED_LEDS-1:0];
            end
            if (ofs_q == 32'(ahb_pkg::GPIO_GREEN_LEDS_OFS)) begin
                green_leds <= bus.hwdata[ahb_pkg::N_GREEN_LEDS-1:0];
            end
        end
    end

    // Unused offsets read as zero
    always_comb begin
        case (ofs_q)
            32'(ahb_pkg::GPIO_SWITCHES_OFS):   bus.hrdata = 32'(sw_sync);
            32'(ahb_pkg::GPIO_BUTTONS_OFS):    bus.hrdata = 32'(btn_sync);
            32'(ahb_pkg::GPIO_RED_LEDS_OFS):   bus.hrdata = 32'(red_leds);
            32'(ahb_pkg::GPIO_GREEN_LEDS_OFS): bus.hrdata = 32'(green_leds);
            default:                           bus.hrdata = 32'h0;
        endcase
    end

    assign bus.hreadyout = 1'b1;
    assign bus.hresp     = ahb_pkg::HRESP_OKAY;

endmodule

/* source/ahb_slave_select.sv */
`timescale 1ns/10ps

module ahb_slave_select (
    input  logic         HCLK,
    input  logic         reset,
    input  logic [31:0]  haddr,
    input  logic [1:0]   htrans,
    input  logic         hwrite,
    input  logic [2:0]   hsize,
    input  logic [31:0]  hwdata,
    output logic [31:0]  hrdata,
    output logic         hready,
    output logic         hresp,
    ahb_slave_if.fabric  ram,
    ahb_slave_if.fabric  gpio
);

    typedef enum logic {
        ERR_FIRST,
        ERR_SECOND
    } err_state_t;

    logic                         trans_valid;
    logic [ahb_pkg::N_SLAVES-1:0] sel;
    logic                         unmapped;
    logic [ahb_pkg::N_SLAVES-1:0] sel_q;
    logic                         unmapped_q;
    err_state_t                   err_state;

    // ------------------------------
    // Address decode
    // ------------------------------

    assign trans_valid = (htrans == ahb_pkg::HTRANS_NONSEQ) || (htrans == ahb_pkg::HTRANS_SEQ);

    assign sel[ahb_pkg::SLAVE_RAM]  = trans_valid &&
                                      ((haddr & ahb_pkg::RAM_MASK) == ahb_pkg::RAM_BASE);
    assign sel[ahb_pkg::SLAVE_GPIO] = trans_valid &&
                                      ((haddr & ahb_pkg::GPIO_MASK) == ahb_pkg::GPIO_BASE);

    assign unmapped = trans_valid && (sel == '0);

    // Both slaves see the same address phase, only hsel differs
    assign ram.hsel    = sel[ahb_pkg::SLAVE_RAM];
    assign ram.haddr   = haddr;
    assign ram.htrans  = htrans;
    assign ram.hwrite  = hwrite;
    assign ram.hsize   = hsize;
    assign ram.hwdata  = hwdata;
    assign ram.hready  = hready;

    assign gpio.hsel   = sel[ahb_pkg::SLAVE_GPIO];
    assign gpio.haddr  = haddr;
    assign gpio.htrans = htrans;
    assign gpio.hwrite = hwrite;
    assign gpio.hsize  = hsize;
    assign gpio.hwdata = hwdata;
    assign gpio.hready = hready;

    // ------------------------------
    // Data phase select
    // ------------------------------

    always_ff @(posedge HCLK) begin
        if (reset) begin
            sel_q      <= '0;
            unmapped_q <= 1'b0;
            err_state  <= ERR_FIRST;
        end else if (hready) begin
            sel_q      <= sel;
            unmapped_q <= unmapped;
            err_state  <= ERR_FIRST;
        end else if (unmapped_q) begin
            // First error cycle is over, release the bus on the next one
            err_state  <= ERR_SECOND;
        end
    end

    // ------------------------------
    // Response multiplexer
    // ------------------------------

    always_comb begin
        if (unmapped_q) begin
            hrdata = 32'h0;
            hready = (err_state == ERR_SECOND);
            hresp  = ahb_pkg::HRESP_ERROR;
        end else if (sel_q[ahb_pkg::SLAVE_RAM]) begin
            hrdata = ram.hrdata;
            hready = ram.hreadyout;
            hresp  = ram.hresp;
        end else if (sel_q[ahb_pkg::SLAVE_GPIO]) begin
            hrdata = gpio.hrdata;
            hready = gpio.hreadyout;
            hresp  = gpio.hresp;
        end else begin
            // IDLE and BUSY transfers complete at once
            hrdata = 32'h0;
            hready = 1'b1;
            hresp  = ahb_pkg::HRESP_OKAY;
        end
    end

endmodule

/* source/ahb_matrix.sv */
`timescale 1ns/10ps

module ahb_matrix (
    input  logic                             HCLK,
    input  logic                             reset,
    input  logic [31:0]                      haddr,
    input  logic [1:0]                       htrans,
    input  logic                             hwrite,
    input  logic [2:0]                       hsize,
    input  logic [31:0]                      hwdata,
    output logic [31:0]                      hrdata,
    output logic                             hready,
    output logic                             hresp,
    input  logic [ahb_pkg::N_SWITCHES-1:0]   switches,
    input  logic [ahb_pkg::N_BUTTONS-1:0]    buttons,
    output logic [ahb_pkg::N_RED_LEDS-1:0]   red_leds,
    output logic [ahb_pkg::N_GREEN_LEDS-1:0] green_leds
);

    ahb_slave_if ram_bus ();
    ahb_slave_if gpio_bus ();

    // ------------------------------
    // Decode and response path
    // ------------------------------

    ahb_slave_select select (
        .HCLK   (HCLK),
        .reset  (reset),
        .haddr  (haddr),
        .htrans (htrans),
        .hwrite (hwrite),
        .hsize  (hsize),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hready (hready),
        .hresp  (hresp),
        .ram    (ram_bus.fabric),
        .gpio   (gpio_bus.fabric)
    );

    // ------------------------------
    // Slaves
    // ------------------------------

    ahb_ram_slave #(
        .WAIT_STATES (ahb_pkg::RAM_WAIT_STATES)
    ) ram (
        .HCLK  (HCLK),
        .reset (reset),
        .bus   (ram_bus.slave)
    );

    // LED outputs come straight from the GPIO registers
    ahb_gpio_slave gpio (
        .HCLK       (HCLK),
        .reset      (reset),
        .bus        (gpio_bus.slave),
        .switches   (switches),
        .buttons    (buttons),
        .red_leds   (red_leds),
        .green_leds (green_leds)
    );

endmodule

/* verif/ahb_master_tasks.svh */
`ifndef AHB_MASTER_TASKS_SVH
`define AHB_MASTER_TASKS_SVH

// Where a transfer lands by the memory map
typedef enum logic [1:0] {KIND_NONE, KIND_RAM, KIND_GPIO, KIND_BAD} kind_t;

// Reference model of the RAM words and the LED registers
logic [31:0] ref_mem [0:2**ahb_pkg::RAM_ADDR_WIDTH-1];
logic [ahb_pkg::N_RED_LEDS-1:0]   ref_red = '0;
logic [ahb_pkg::N_GREEN_LEDS-1:0] ref_green = '0;

// Transfer that is in its data phase
kind_t       pend_kind = KIND_NONE;
logic [31:0] pend_addr = '0;
logic        pend_write = 1'b0;
logic [2:0]  pend_size = ahb_pkg::HSIZE_WORD;
logic [31:0] pend_wdata = '0;

function automatic kind_t kind_of(input logic [1:0] trans, input logic [31:0] addr);
    if (!trans[1]) return KIND_NONE;
    if ((addr & ahb_pkg::RAM_MASK) == ahb_pkg::RAM_BASE) return KIND_RAM;
    if ((addr & ahb_pkg::GPIO_MASK) == ahb_pkg::GPIO_BASE) return KIND_GPIO;
    return KIND_BAD;
endfunction

// A byte goes to lane ofs and a halfword to the lane pair picked by ofs[1]
function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] data,
                                            input logic [1:0] ofs, input logic [2:0] size);
    logic [31:0] result;
    result = old;
    for (int i = 0; i < 4; i++) begin
        if (size == ahb_pkg::HSIZE_WORD || i == ofs ||
            (size == ahb_pkg::HSIZE_HALF && i / 2 == ofs[1])) begin
            result[i*8 +: 8] = data[i*8 +: 8];
        end
    end
    return result;
endfunction

function automatic logic [31:0] expected_read(input kind_t kind, input logic [31:0] addr);
    if (kind == KIND_RAM) return ref_mem[addr[ahb_pkg::RAM_ADDR_WIDTH+1:2]];
    case (addr[11:0])
        12'(ahb_pkg::GPIO_SWITCHES_OFS):   return 32'(switches);
        12'(ahb_pkg::GPIO_BUTTONS_OFS):    return 32'(buttons);
        12'(ahb_pkg::GPIO_RED_LEDS_OFS):   return 32'(ref_red);
        12'(ahb_pkg::GPIO_GREEN_LEDS_OFS): return 32'(ref_green);
        default:                           return 32'h0;
    endcase
endfunction

// Called at the edge that ends the data phase of the pending transfer
task automatic close_data_phase(input int waits);
    expect_equal(waits, (pend_kind == KIND_RAM) ? ahb_pkg::RAM_WAIT_STATES :
                        (pend_kind == KIND_BAD) ? 1 : 0, "wait states");
    expect_equal(hresp, pend_kind == KIND_BAD, "hresp at end of data phase");
    if (!pend_write && (pend_kind == KIND_RAM || pend_kind == KIND_GPIO)) begin
        expect_equal(hrdata, expected_read(pend_kind, pend_addr), "hrdata");
    end
    if (pend_write && pend_kind == KIND_RAM) begin
        ref_mem[pend_addr[ahb_pkg::RAM_ADDR_WIDTH+1:2]] =
            merge_lanes(ref_mem[pend_addr[ahb_pkg::RAM_ADDR_WIDTH+1:2]], pend_wdata,
                        pend_addr[1:0], pend_size);
    end
    if (pend_write && pend_kind == KIND_GPIO && pend_size == ahb_pkg::HSIZE_WORD) begin
        if (pend_addr[11:0] == 12'(ahb_pkg::GPIO_RED_LEDS_OFS)) begin
            ref_red = pend_wdata[ahb_pkg::N_RED_LEDS-1:0];
        end
        if (pend_addr[11:0] == 12'(ahb_pkg::GPIO_GREEN_LEDS_OFS)) begin
            ref_green = pend_wdata[ahb_pkg::N_GREEN_LEDS-1:0];
        end
    end
    #1;
    expect_equal(red_leds, ref_red, "red_leds");
    expect_equal(green_leds, ref_green, "green_leds");
endtask

// Drives one address phase while the previous transfer runs its data phase
task automatic transfer(input logic [1:0] trans, input logic [31:0] addr, input logic write,
                        input logic [2:0] size, input logic [31:0] wdata);
    int waits;
    @(negedge HCLK);
    htrans = trans;
    haddr  = addr;
    hwrite = write;
    hsize  = size;
    hwdata = pend_wdata;
    waits  = 0;
    @(posedge HCLK);
    while (!hready) begin
        expect_equal(hresp, pend_kind == KIND_BAD, "hresp while hready is low");
        waits++;
        if (waits > hready_limit) abort_on_timeout();
        @(posedge HCLK);
    end
    close_data_phase(waits);
    pend_kind  = kind_of(trans, addr);
    pend_addr  = addr;
    pend_write = write;
    pend_size  = size;
    pend_wdata = wdata;
endtask

task automatic write_at(input logic [31:0] addr, input logic [2:0] size,
                        input logic [31:0] data);
    transfer(ahb_pkg::HTRANS_NONSEQ, addr, 1'b1, size, data);
endtask

task automatic read_at(input logic [31:0] addr);
    transfer(ahb_pkg::HTRANS_NONSEQ, addr, 1'b0, ahb_pkg::HSIZE_WORD, 32'h0);
endtask

task automatic idle_cycle();
    transfer(ahb_pkg::HTRANS_IDLE, 32'h0, 1'b0, ahb_pkg::HSIZE_WORD, 32'h0);
endtask

`endif

/* verif/tb_ahb_matrix.sv */
`timescale 1ns/10ps

module tb_ahb_matrix;

    logic                             HCLK;
    logic                             reset;
    logic [31:0]                      haddr;
    logic [1:0]                       htrans;
    logic                             hwrite;
    logic [2:0]                       hsize;
    logic [31:0]                      hwdata;
    logic [31:0]                      hrdata;
    logic                             hready;
    logic                             hresp;
    logic [ahb_pkg::N_SWITCHES-1:0]   switches;
    logic [ahb_pkg::N_BUTTONS-1:0]    buttons;
    logic [ahb_pkg::N_RED_LEDS-1:0]   red_leds;
    logic [ahb_pkg::N_GREEN_LEDS-1:0] green_leds;

    integer      seed = 32'h710f_dd97;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          errors_at_start = 0;
    int          hready_limit = 20;
    logic [31:0] ram_addrs [8];
    logic [31:0] addr;
    logic [31:0] data;

    ahb_matrix dut (.*);

    always #20 HCLK = ~HCLK;

    task automatic note_error(input string msg);
        errors++;
        $display("** Error at %0t: %s", $time, msg);
    endtask

    task automatic expect_equal(input logic [31:0] got, input logic [31:0] want,
                                input string what);
        checks++;
        assert (got === want)
        else note_error($sformatf("%s is %h, expected %h", what, got, want));
    endtask

    task automatic abort_on_timeout();
        $display("timeout waiting for hready, stopped after %0d cycles", hready_limit);
        $display("RESULT: FAIL");
        $finish;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d (%s) done, %0d errors", tests, name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    `include "ahb_master_tasks.svh"

    // ------------------------------
    // Protocol checks
    // ------------------------------

    // An error response is low then high and never longer
    assert property (@(posedge HCLK) disable iff (reset) (!hready && hresp) |=> (hready && hresp))
    else note_error("error response did not end in its second cycle");

    assert property (@(posedge HCLK) disable iff (reset) $rose(hresp) |-> !hready)
    else note_error("error response started with hready high");

    assert property (@(posedge HCLK) disable iff (reset)
        (hready && htrans == ahb_pkg::HTRANS_IDLE) |=> (hready && hresp == ahb_pkg::HRESP_OKAY))
    else note_error("IDLE transfer did not complete in one cycle with OKAY");

    initial begin
        HCLK     = 1'b0;
        reset    = 1'b1;
        haddr    = '0;
        htrans   = ahb_pkg::HTRANS_IDLE;
        hwrite   = 1'b0;
        hsize    = ahb_pkg::HSIZE_WORD;
        hwdata   = '0;
        switches = '0;
        buttons  = '0;
        repeat (10) @(posedge HCLK);
        @(negedge HCLK);
        reset = 1'b0;
        expect_equal(hready, 1'b1, "hready after reset");
        expect_equal(hresp, ahb_pkg::HRESP_OKAY, "hresp after reset");
        expect_equal({red_leds, green_leds}, '0, "LEDs after reset");
        end_test("reset");

        for (int i = 0; i < 8; i++) begin
            ram_addrs[i] = $random(seed) & 32'h0000_0FFC;
            write_at(ram_addrs[i], ahb_pkg::HSIZE_WORD, $random(seed));
        end
        for (int i = 0; i < 8; i++) read_at(ram_addrs[i]);
        idle_cycle();
        end_test("ram words");

        for (int i = 0; i < 8; i++) begin
            write_at(ram_addrs[i] | 32'(i % 4), ahb_pkg::HSIZE_BYTE, $random(seed));
            write_at(ram_addrs[i] | 32'((i % 2) * 2), ahb_pkg::HSIZE_HALF, $random(seed));
            read_at(ram_addrs[i]);
        end
        idle_cycle();
        end_test("ram byte lanes");

        data = $random(seed);
        write_at(ahb_pkg::GPIO_BASE | ahb_pkg::GPIO_RED_LEDS_OFS, ahb_pkg::HSIZE_WORD, data);
        write_at(ahb_pkg::GPIO_BASE | ahb_pkg::GPIO_GREEN_LEDS_OFS, ahb_pkg::HSIZE_WORD, ~data);
        write_at(ahb_pkg::GPIO_BASE | ahb_pkg::GPIO_SWITCHES_OFS, ahb_pkg::HSIZE_WORD, data);
        read_at(ahb_pkg::GPIO_BASE | ahb_pkg::GPIO_RED_LEDS_OFS);
        read_at(ahb_pkg::GPIO_BASE | ahb_pkg::GPIO_GREEN_LEDS_OFS);
        read_at(ahb_pkg::GPIO_BASE | ahb_pkg::GPIO_SWITCHES_OFS);
        idle_cycle();
        @(negedge HCLK);
        data     = $random(seed);
        switches = data[ahb_pkg::N_SWITCHES-1:0];
        data     = $random(seed);
        buttons  = data[ahb_pkg::N_BUTTONS-1:0];
        repeat (3) @(negedge HCLK);
        read_at(ahb_pkg::GPIO_BASE | ahb_pkg::GPIO_SWITCHES_OFS);
        read_at(ahb_pkg::GPIO_BASE | ahb_pkg::GPIO_BUTTONS_OFS);
        idle_cycle();
        end_test("gpio");

        read_at(32'h4000_0000);
        write_at(32'h8000_0010, ahb_pkg::HSIZE_WORD, data);
        read_at(ram_addrs[0]);
        idle_cycle();
        end_test("unmapped");

        // Mix of RAM, GPIO and IDLE with no gaps between transfers
        for (int i = 0; i < 60; i++) begin
            data = $random(seed);
            addr = ram_addrs[data[2:0]] | 32'(data[4:3]);
            case (data[7:5])
                0, 1: idle_cycle();
                2: read_at(addr & ~32'h3);
                3: write_at(addr, ahb_pkg::HSIZE_BYTE, data);
                4: write_at(addr & ~32'h1, ahb_pkg::HSIZE_HALF, data);
                5: write_at(addr & ~32'h3, ahb_pkg::HSIZE_WORD, data);
                6: read_at(ahb_pkg::GPIO_BASE | {data[12:10], 2'b00});
                default: write_at(ahb_pkg::GPIO_BASE | {data[12:11], 2'b00},
                                  ahb_pkg::HSIZE_WORD, data);
            endcase
        end
        idle_cycle();
        end_test("pipelined mix");

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+verif
common/ahb_pkg.sv
common/ahb_slave_if.sv
ram/ahb_ram_slave.sv
gpio/ahb_gpio_slave.sv
source/ahb_slave_select.sv
source/ahb_matrix.sv
verif/tb_ahb_matrix.sv
